// File: hdl/scan_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scan_apb_regs import scan_pkg::*;
#(
  parameter int NUM_LANES = 4
)
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [7:0]                           paddr,
  input  logic [31:0]                          pwdata,
  output logic [31:0]                          prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  output logic [NUM_LANES*$bits(pattern_t)-1:0] patterns,
  output logic [NUM_LANES*$bits(pat_len_t)-1:0] pat_lens,
  output logic [NUM_LANES-1:0]                 enables,
  input  logic [NUM_LANES*$bits(count_t)-1:0]   counts,
  output logic [NUM_LANES-1:0]                 count_clrs
);

  pattern_t pat_q [NUM_LANES];
  pat_len_t len_q [NUM_LANES];
  logic [NUM_LANES-1:0] en_q;

  logic [3:0] lane_idx;
  logic [3:0] offset;
  logic       lane_ok;
  logic       access;

  assign lane_idx = paddr[7:4];
  assign offset   = paddr[3:0];
  assign lane_ok  = int'(lane_idx) < NUM_LANES;
  // Second cycle of a transfer, no wait states
  assign access   = psel & penable;

  assign pready  = 1'b1;
  assign pslverr = access & ~lane_ok;

  // Read mux, zero for unknown offsets or lanes
  always_comb
  begin
    prdata = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (lane_idx == 4'(i))
      begin
        case (offset)
          REG_PAT_LO: prdata = pat_q[i][31:0];
          REG_PAT_HI: prdata = pat_q[i][63:32];
          REG_CTRL:   prdata = {23'b0, en_q[i], 4'b0, len_q[i]};
          REG_COUNT:  prdata = 32'(counts[i*$bits(count_t) +: $bits(count_t)]);
          default:    prdata = '0;
        endcase
      end
    end
  end

  // Register writes and count clear pulses
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      en_q       <= '0;
      count_clrs <= '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
        pat_q[i] <= '0;
        len_q[i] <= '0;
      end
    end
    else
    begin
      count_clrs <= '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
        if (access && pwrite && lane_idx == 4'(i))
        begin
          case (offset)
            REG_PAT_LO: pat_q[i][31:0]  <= pwdata;
            REG_PAT_HI: pat_q[i][63:32] <= pwdata;
            REG_CTRL:
            begin
              len_q[i] <= pwdata[3:0];
              en_q[i]  <= pwdata[CTRL_EN_BIT];
            end
            REG_COUNT:  count_clrs[i] <= 1'b1;
            default:    ;
          endcase
        end
      end
    end
  end

  // Flatten lane settings
  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_flat
    assign patterns[g*$bits(pattern_t) +: $bits(pattern_t)] = pat_q[g];
    assign pat_lens[g*$bits(pat_len_t) +: $bits(pat_len_t)] = len_q[g];
  end
  assign enables = en_q;

  // Access phase must come right after a setup phase
  a_apb_phase: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

// File: hdl/scan_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module scan_dispatch import scan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_vld,
  input  logic       in_sop,
  input  logic       in_eop,
  input  char_t      in_char,
  input  stream_id_t in_stream,
  output logic       load_state,
  output logic       new_stream,
  output logic       char_vld,
  output logic       eop,
  output char_t      char_in,
  output stream_id_t stream_id
);

  // One bit per stream id, set once a packet of it has started
  logic [STREAM_COUNT-1:0] seen;

  // High between sop and eop of the current input packet
  logic pkt_open;

  // Strobes and the seen bitmap
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_state <= 1'b0;
      new_stream <= 1'b0;
      char_vld   <= 1'b0;
      eop        <= 1'b0;
      seen       <= '0;
      pkt_open   <= 1'b0;
    end
    else
    begin
      load_state <= in_vld & in_sop;
      char_vld   <= in_vld;
      eop        <= in_vld & in_eop;
      // Bitmap value before this packet decides fresh start
      new_stream <= in_vld & in_sop & ~seen[in_stream];
      if (in_vld && in_sop)
        seen[in_stream] <= 1'b1;
      if (in_vld && in_eop)
        pkt_open <= 1'b0;
      else if (in_vld && in_sop)
        pkt_open <= 1'b1;
    end
  end

  // Payload path, stream id only taken at sop
  always_ff @(posedge clk)
  begin
    char_in <= in_char;
    if (in_vld && in_sop)
      stream_id <= in_stream;
  end

  // Framing bits only mean something with a valid byte
  a_sop_eop_vld: assert property (@(posedge clk) disable iff (!rst_n)
    (in_sop || in_eop) |-> in_vld);

  // Stream id held for the whole packet
  a_stream_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (in_vld && pkt_open && !in_sop) |-> (in_stream == stream_id));

endmodule

`default_nettype wire

// File: hdl/scan_lane.sv
`timescale 1ns/1ps
`default_nettype none

module scan_lane import scan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load_state,
  input  logic       new_stream,
  input  logic       char_vld,
  input  logic       eop,
  input  char_t      char_in,
  input  stream_id_t stream_id,
  input  pattern_t   pattern,
  input  pat_len_t   pat_len,
  input  logic       enable,
  input  logic       count_clr,
  output count_t     count
);

  // Saved history per stream
  history_t hist_mem [STREAM_COUNT];

  // Working history of the packet in flight
  history_t hist_q;

  // Set once the pattern hit somewhere in this packet
  logic match_flag;

  history_t cur_hist;
  pattern_t window;
  pattern_t match_mask;
  pat_len_t eff_len;
  logic     match;
  logic     pkt_match;

  // Restore on the first beat, fresh streams start empty
  always_comb
  begin
    if (load_state)
      cur_hist = new_stream ? '0 : hist_mem[stream_id];
    else
      cur_hist = hist_q;
  end

  // Current byte lands in byte 0, older bytes move up
  assign window = {cur_hist, char_in};

  // Zero length treated as one byte
  assign eff_len = (pat_len == '0) ? pat_len_t'(1) : pat_len;

  // Keep only the low eff_len bytes in the compare
  always_comb
  begin
    match_mask = '0;
    for (int k = 0; k < 8; k++)
    begin
      if (k < int'(eff_len))
        match_mask[k*8 +: 8] = 8'hff;
    end
  end

  assign match = char_vld && (((window ^ pattern) & match_mask) == '0);

  // Flag including a hit on this very beat
  assign pkt_match = match_flag | match;

  // History shift and save
  always_ff @(posedge clk)
  begin
    if (char_vld)
      hist_q <= window[55:0];
    // Persist at eop regardless of enable
    if (eop)
      hist_mem[stream_id] <= window[55:0];
  end

  // Match flag and packet counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      match_flag <= 1'b0;
      count      <= '0;
    end
    else
    begin
      if (eop)
        match_flag <= 1'b0;
      else
        match_flag <= pkt_match;
      // Clear wins over a same-cycle increment
      if (count_clr)
        count <= '0;
      else if (eop && enable)
        count <= count + count_t'(pkt_match);
    end
  end

  // End of packet always rides on a valid byte
  a_eop_vld: assert property (@(posedge clk) disable iff (!rst_n)
    eop |-> char_vld);

endmodule

`default_nettype wire

// File: hdl/scan_pkg.sv
`default_nettype none

package scan_pkg;

  // Stream id space
  localparam int STREAM_COUNT = 64;

  // One payload byte
  typedef logic [7:0] char_t;

  // Stream identifier
  typedef logic [5:0] stream_id_t;

  // Seven most recent bytes, byte 0 is the newest
  typedef logic [55:0] history_t;

  // Byte k matches the byte k positions back, byte 0 is the current byte
  typedef logic [63:0] pattern_t;

  // Length 1 to 8, zero acts as 1
  typedef logic [3:0] pat_len_t;

  // Matched packet count, wraps
  typedef logic [15:0] count_t;

  // Offsets inside the 16-byte window of each lane
  localparam logic [3:0] REG_PAT_LO = 4'h0;
  localparam logic [3:0] REG_PAT_HI = 4'h4;
  localparam logic [3:0] REG_CTRL   = 4'h8;
  localparam logic [3:0] REG_COUNT  = 4'hc;

  // Enable position in the control word
  localparam int CTRL_EN_BIT = 8;

endpackage

`default_nettype wire

// File: hdl/scan_top.sv
`timescale 1ns/1ps
`default_nettype none

module scan_top import scan_pkg::*;
#(
  parameter int NUM_LANES = 4
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_vld,
  input  logic        in_sop,
  input  logic        in_eop,
  input  char_t       in_char,
  input  stream_id_t  in_stream,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  // Broadcast from dispatcher to every lane
  logic       load_state;
  logic       new_stream;
  logic       char_vld;
  logic       eop;
  char_t      char_in;
  stream_id_t stream_id;

  // Lane settings and counts, flat per lane
  logic [NUM_LANES*$bits(pattern_t)-1:0] patterns;
  logic [NUM_LANES*$bits(pat_len_t)-1:0] pat_lens;
  logic [NUM_LANES-1:0]                 enables;
  logic [NUM_LANES*$bits(count_t)-1:0]   counts;
  logic [NUM_LANES-1:0]                 count_clrs;

  scan_dispatch i_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_vld     (in_vld),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_char    (in_char),
    .in_stream  (in_stream),
    .load_state (load_state),
    .new_stream (new_stream),
    .char_vld   (char_vld),
    .eop        (eop),
    .char_in    (char_in),
    .stream_id  (stream_id)
  );

  // One matcher per programmable pattern
  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_lane
    scan_lane i_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .new_stream (new_stream),
      .char_vld   (char_vld),
      .eop        (eop),
      .char_in    (char_in),
      .stream_id  (stream_id),
      .pattern    (patterns[g*$bits(pattern_t) +: $bits(pattern_t)]),
      .pat_len    (pat_lens[g*$bits(pat_len_t) +: $bits(pat_len_t)]),
      .enable     (enables[g]),
      .count_clr  (count_clrs[g]),
      .count      (counts[g*$bits(count_t) +: $bits(count_t)])
    );
  end

  scan_apb_regs #(
    .NUM_LANES (NUM_LANES)
  ) i_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .patterns   (patterns),
    .pat_lens   (pat_lens),
    .enables    (enables),
    .counts     (counts),
    .count_clrs (count_clrs)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the scanner testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f scan_top.f --top-module scan_tb --Mdir obj_dir -o scan_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/scan_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// File: scan_top.f
+incdir+test
hdl/scan_pkg.sv
hdl/scan_dispatch.sv
hdl/scan_lane.sv
hdl/scan_apb_regs.sv
hdl/scan_top.sv
test/scan_tb.sv

// File: test/scan_model.svh
`ifndef SCAN_MODEL_SVH
`define SCAN_MODEL_SVH

// Xorshift state, fixed seed
logic [31:0] rng_state = 32'heb6b6f54;

// Expected history and seen set per stream
history_t ref_hist [STREAM_COUNT];
logic     ref_seen [STREAM_COUNT];

// Lane settings as last programmed
pattern_t ref_pat [NUM_LANES];
pat_len_t ref_len [NUM_LANES];
logic     ref_en  [NUM_LANES];

// Hit seen in the current packet, and the expected count
logic     ref_flag  [NUM_LANES];
count_t   ref_count [NUM_LANES];

function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic void reset_model();
  for (int s = 0; s < STREAM_COUNT; s++)
  begin
    ref_hist[s] = '0;
    ref_seen[s] = 1'b0;
  end
  for (int i = 0; i < NUM_LANES; i++)
  begin
    ref_pat[i]   = '0;
    ref_len[i]   = '0;
    ref_en[i]    = 1'b0;
    ref_flag[i]  = 1'b0;
    ref_count[i] = '0;
  end
endfunction

// Byte k of the pattern against the byte k positions back
function automatic logic lane_hit(input int lane, input history_t hist, input char_t ch);
  int    len;
  char_t back;
  logic  hit;
  len = (ref_len[lane] == 4'd0) ? 1 : int'(ref_len[lane]);
  if (len > 8)
    len = 8;
  hit = 1'b1;
  for (int k = 0; k < len; k++)
  begin
    if (k == 0)
      back = ch;
    else
      back = hist[(k - 1) * 8 +: 8];
    if (back != ref_pat[lane][k * 8 +: 8])
      hit = 1'b0;
  end
  return hit;
endfunction

// One payload byte through every lane
function automatic void scan_byte(input stream_id_t stream, input char_t ch,
                                  input logic sop, input logic eop);
  // A stream never seen before starts empty
  if (sop && !ref_seen[stream])
  begin
    ref_hist[stream] = '0;
    ref_seen[stream] = 1'b1;
  end
  for (int i = 0; i < NUM_LANES; i++)
  begin
    if (lane_hit(i, ref_hist[stream], ch))
      ref_flag[i] = 1'b1;
  end
  // History moves on whether or not a lane is enabled
  ref_hist[stream] = {ref_hist[stream][47:0], ch};
  if (eop)
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (ref_en[i] && ref_flag[i])
        ref_count[i] = ref_count[i] + count_t'(1);
      ref_flag[i] = 1'b0;
    end
  end
endfunction

`endif

// File: test/scan_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scan_tb
  import scan_pkg::*;
();

  localparam int NUM_LANES      = 4;
  localparam int NUM_BATCHES    = 8;
  localparam int PKTS_PER_BATCH = 24;
  localparam int MAX_PKT_LEN    = 12;
  localparam int MAX_GAP        = 2;
  localparam int IDLE_CYCLES    = 4;
  // APB transfers planned, three cycles each
  localparam int APB_OPS = NUM_LANES * 9 + 3 + NUM_BATCHES * (NUM_LANES * 4 + 2);
  localparam int PKT_CYCLES =
    NUM_BATCHES * (PKTS_PER_BATCH * (MAX_PKT_LEN + MAX_GAP) + IDLE_CYCLES);
  localparam int TIMEOUT_CYCLES = 2 * (PKT_CYCLES + 3 * APB_OPS + 8);

  logic        clk;
  logic        rst_n;
  logic        in_vld;
  logic        in_sop;
  logic        in_eop;
  char_t       in_char;
  stream_id_t  in_stream;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          cycle_count = 0;

  `include "scan_model.svh"

  scan_top #(
    .NUM_LANES (NUM_LANES)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_char   (in_char),
    .in_stream (in_stream),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Watchdog against a stuck run
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
      abort_run("Timeout, the run went past its cycle budget");
  end

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_rdata(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp)
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_slverr(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  // Lane index in the upper nibble
  function automatic logic [7:0] reg_addr(input int lane, input logic [3:0] off);
    return {lane[3:0], off};
  endfunction

  // Setup then access, sample halfway through the access cycle
  task automatic apb_xfer(input logic write, input logic [7:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    // No wait states, so the access phase must end here
    if (pready !== 1'b1)
      abort_run("APB slave held pready low in the access phase");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input int lane, input logic [3:0] off, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, reg_addr(lane, off), data, rdata, err);
    check_slverr("write error flag", lane >= NUM_LANES, err);
  endtask

  task automatic read_reg(input int lane, input logic [3:0] off, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, reg_addr(lane, off), 32'h0, data, err);
    check_slverr("read error flag", lane >= NUM_LANES, err);
  endtask

  task automatic program_lane(input int lane, input pattern_t pat, input pat_len_t len,
                              input logic en);
    write_reg(lane, REG_PAT_LO, pat[31:0]);
    write_reg(lane, REG_PAT_HI, pat[63:32]);
    write_reg(lane, REG_CTRL, {23'b0, en, 4'b0, len});
    ref_pat[lane] = pat;
    ref_len[lane] = len;
    ref_en[lane]  = en;
  endtask

  task automatic check_counts(input string name);
    logic [31:0] data;
    for (int lane = 0; lane < NUM_LANES; lane++)
    begin
      read_reg(lane, REG_COUNT, data);
      check_count(name, ref_count[lane], count_t'(data));
    end
  endtask

  // Four letters only, so short patterns hit often
  function automatic char_t random_char();
    logic [31:0] r;
    r = next_random();
    return 8'h41 + {6'b0, r[9:8]};
  endfunction

  task automatic go_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_vld <= 1'b0;
      in_sop <= 1'b0;
      in_eop <= 1'b0;
    end
  endtask

  // Back to back beats, then a short random gap
  task automatic send_packet(input stream_id_t stream, input int len);
    logic [31:0] r;
    char_t       ch;
    for (int i = 0; i < len; i++)
    begin
      ch = random_char();
      @(posedge clk);
      in_vld    <= 1'b1;
      in_sop    <= (i == 0);
      in_eop    <= (i == len - 1);
      in_char   <= ch;
      in_stream <= stream;
      scan_byte(stream, ch, i == 0, i == len - 1);
    end
    r = next_random();
    go_idle(int'(r[1:0]) % (MAX_GAP + 1));
  endtask

  initial
  begin
    logic [31:0] data;
    logic [31:0] r;
    logic [31:0] ctrl;
    pattern_t    pat;
    stream_id_t  stream;
    string       name;
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_vld      = 1'b0;
    in_sop      = 1'b0;
    in_eop      = 1'b0;
    in_char     = '0;
    in_stream   = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    reset_model();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_counts("reset counts");

    // Register readback, control keeps only length and enable
    for (int lane = 0; lane < NUM_LANES; lane++)
    begin
      pat  = {next_random(), next_random()};
      ctrl = next_random();
      write_reg(lane, REG_PAT_LO, pat[31:0]);
      write_reg(lane, REG_PAT_HI, pat[63:32]);
      write_reg(lane, REG_CTRL, ctrl);
      read_reg(lane, REG_PAT_LO, data);
      check_rdata("pattern low readback", pat[31:0], data);
      read_reg(lane, REG_PAT_HI, data);
      check_rdata("pattern high readback", pat[63:32], data);
      read_reg(lane, REG_CTRL, data);
      check_rdata("control readback", ctrl & 32'h0000_010f, data);
    end

    // Lanes past the last one answer with an error and zero data
    write_reg(NUM_LANES, REG_PAT_LO, 32'hffff_ffff);
    read_reg(NUM_LANES, REG_PAT_LO, data);
    check_rdata("out of range read", 32'h0, data);
    read_reg(15, REG_COUNT, data);
    check_rdata("top lane index read", 32'h0, data);

    for (int b = 0; b < NUM_BATCHES; b++)
    begin
      // Halfway reset, stale history memory must not leak into new streams
      if (b == NUM_BATCHES / 2)
      begin
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        reset_model();
        check_counts("counts after reset");
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
          read_reg(lane, REG_CTRL, data);
          check_rdata("control after reset", 32'h0, data);
        end
      end
      for (int lane = 0; lane < NUM_LANES; lane++)
      begin
        for (int k = 0; k < 8; k++)
          pat[k * 8 +: 8] = random_char();
        r = next_random();
        // Lengths rotate through 1 to 8, first batch has every lane on
        program_lane(lane, pat, pat_len_t'((b + lane) % 8 + 1), (b == 0) || r[0]);
      end
      for (int p = 0; p < PKTS_PER_BATCH; p++)
      begin
        r = next_random();
        // One stream first, then a sliding window that restarts after the reset
        if (b == 0)
          stream = 6'd5;
        else
          stream = stream_id_t'((int'(r[3:2]) + (b % (NUM_BATCHES / 2)) * 3)
                                % STREAM_COUNT);
        send_packet(stream, int'(r[7:4]) % MAX_PKT_LEN + 1);
      end
      go_idle(IDLE_CYCLES);
      if (b == 0)
        name = "single stream counts";
      else
        name = "interleaved stream counts";
      check_counts(name);
      // Clear one lane and see it back at zero
      write_reg(b % NUM_LANES, REG_COUNT, 32'h0);
      ref_count[b % NUM_LANES] = '0;
      read_reg(b % NUM_LANES, REG_COUNT, data);
      check_count("count clear", '0, count_t'(data));
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
